/* include/icache_defs.svh */
/*
  Instruction cache geometry: address, tag, set, offset and word widths
*/
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Byte address presented by the fetch stage
`define ICACHE_ADDR_BITS 32

// Instruction word width on the bus and in the data arrays
`define ICACHE_WORD_BITS 32

// 16 sets, 4 words per block
`define ICACHE_SET_BITS 4
`define ICACHE_OFFSET_BITS 2

// Word aligned, so the low two bits never reach the cache
`define ICACHE_BYTE_BITS 2

// Whatever is left above set and offset
`define ICACHE_TAG_BITS \
  (`ICACHE_ADDR_BITS - `ICACHE_SET_BITS - `ICACHE_OFFSET_BITS - `ICACHE_BYTE_BITS)

`endif

/* source/cache_pkg.sv */
/*
  Cache storage types: tag, set index, word offset and tag entry
*/
`include "icache_defs.svh"

package cachePkg;

  // Upper address bits kept per block
  typedef logic [`ICACHE_TAG_BITS-1:0] tagT;

  // Selects one of the sets in each way
  typedef logic [`ICACHE_SET_BITS-1:0] setT;

  // Word position inside a four-word block
  typedef logic [`ICACHE_OFFSET_BITS-1:0] offsetT;

  // One entry of a tag array
  typedef struct packed {
    logic valid;
    tagT  tag;
  } tagEntryT;

endpackage

/* source/bus_pkg.sv */
/*
  Memory-side types shared by the fetch stage and the bus
*/
`include "icache_defs.svh"

package busPkg;

  // Physical byte address
  typedef logic [`ICACHE_ADDR_BITS-1:0] addrT;

  // One instruction as it comes off the bus
  typedef logic [`ICACHE_WORD_BITS-1:0] wordT;

endpackage

/* source/cacheArray.sv */
/*
  Cache storage array with asynchronous read and synchronous write,
  shared by the tag and data arrays of both ways
*/
module cacheArray #(
  parameter type entryT = logic [31:0],
  parameter int  depth  = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] wAddr,
  input  logic [$clog2(depth)-1:0] rAddr,
  input  entryT                    wData,
  output entryT                    rData
);

  entryT mem [depth];

  // Clearing on reset drops every tag valid bit at once
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[wAddr] <= wData;
    end
  end

  // Read port follows the address in the same cycle
  assign rData = mem[rAddr];

endmodule

/* source/lruTable.sv */
/*
  Least-recently-used table, one bit per set of the two-way cache
*/
`include "icache_defs.svh"

module lruTable (
  input  logic           clk,
  input  logic           reset,
  input  logic           access,
  input  cachePkg::setT  set,
  input  logic           usedWay1,
  output logic           curLru
);

  localparam int NumSets = 1 << `ICACHE_SET_BITS;

  // Bit high means way 2 was touched last, so way 1 goes next
  logic [NumSets-1:0] lruBits;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (access) begin
      lruBits[set] <= ~usedWay1;
    end
  end

  // Victim hint for the set being looked up
  assign curLru = lruBits[set];

endmodule

/* source/icacheController.sv */
/*
  Instruction cache controller: tag compare, miss FSM, bus beat
  counter and way write enables
*/
module icacheController (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  logic             paReady,
  input  logic             way1Valid,
  input  logic             way2Valid,
  input  logic             curLru,
  input  logic             busReady,
  input  cachePkg::offsetT wordOffset,
  input  cachePkg::tagT    way1Tag,
  input  cachePkg::tagT    way2Tag,
  input  cachePkg::tagT    physTag,
  output cachePkg::offsetT counter,
  output cachePkg::offsetT newWordOffset,
  output logic             way1We,
  output logic             way2We,
  output logic             waySel,
  output logic             iStall,
  output logic             resetBlockOff,
  output logic             busRequest
);

  typedef enum logic [1:0] {READY, MEMREAD, NEXTINSTR} stateT;

  stateT            state, nextState;
  cachePkg::tagT    storedTag, curTag;
  cachePkg::offsetT beatCount;
  logic             way1Hit, way2Hit, hit;
  logic             missStart, beatDone, lastBeat;
  logic             fillWay1;

  // Tag of the access in flight, held once paReady drops
  always_ff @(posedge clk) begin
    if (paReady) begin
      storedTag <= physTag;
    end
  end

  assign curTag = paReady ? physTag : storedTag;

  assign way1Hit = way1Valid & (curTag == way1Tag);
  assign way2Hit = way2Valid & (curTag == way2Tag);
  assign hit     = (way1Hit | way2Hit) & enable;

  // Disabled cache reads only way 1
  assign waySel = enable ? way1Hit : 1'b1;

  // A new request that the arrays cannot serve
  assign missStart = (state == READY) & paReady & ~hit;

  assign busRequest = missStart | (state == MEMREAD);
  assign iStall     = busRequest;

  // One write per beat; disabled mode needs just the requested word
  assign beatDone = busRequest & busReady;
  assign lastBeat = beatDone & ((&beatCount) | ~enable);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      READY:     if (missStart) nextState = lastBeat ? NEXTINSTR : MEMREAD;
      MEMREAD:   if (lastBeat) nextState = NEXTINSTR;
      NEXTINSTR: nextState = READY;
      default:   nextState = READY;
    endcase
  end

  // Completed access, either a hit or the settle cycle after a fill
  assign resetBlockOff = ((state == READY) & paReady & hit) | (state == NEXTINSTR);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (resetBlockOff) begin
      beatCount <= '0;
    end else if (beatDone) begin
      beatCount <= beatCount + cachePkg::offsetT'(1);
    end
  end

  // Disabled mode fetches the requested word, not the whole block
  assign counter = enable ? beatCount : wordOffset;

  // Data arrays follow the bus during a fill, the fetch address otherwise
  assign newWordOffset = busRequest ? counter : wordOffset;

  // Once the first beat lands, the way being filled hits and keeps the choice
  assign fillWay1 = ((((~way1Valid & way2Valid) | curLru) & ~way2Hit) | way1Hit) | ~enable;

  assign way1We = beatDone & fillWay1;
  assign way2We = beatDone & ~fillWay1;

endmodule

/* source/instrCache.sv */
/*
  Two-way set-associative instruction cache, 16 sets of four-word
  blocks, filled from the bus on a miss
*/
`include "icache_defs.svh"

module instrCache (
  input  logic          clk,
  input  logic          reset,
  input  logic          enable,
  input  logic          paReady,
  input  busPkg::addrT  physAddr,
  input  logic          busReady,
  input  busPkg::wordT  busData,
  output busPkg::wordT  instr,
  output logic          iStall,
  output logic          busRequest,
  output busPkg::addrT  busAddr
);

  localparam int TagDepth  = 1 << `ICACHE_SET_BITS;
  localparam int DataDepth = 1 << (`ICACHE_SET_BITS + `ICACHE_OFFSET_BITS);

  cachePkg::tagT      physTag;
  cachePkg::setT      set;
  cachePkg::offsetT   wordOffset, counter, newWordOffset;
  cachePkg::tagEntryT way1Entry, way2Entry, tagWData;
  busPkg::wordT       way1Data, way2Data;
  logic               way1We, way2We, waySel, curLru, resetBlockOff;
  logic [`ICACHE_SET_BITS+`ICACHE_OFFSET_BITS-1:0] dataAddr;

  // Address fields: tag | set | word | byte
  assign physTag    = physAddr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  assign set        = physAddr[`ICACHE_BYTE_BITS+`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
  assign wordOffset = physAddr[`ICACHE_BYTE_BITS +: `ICACHE_OFFSET_BITS];

  // Block address plus the beat being fetched
  assign busAddr = {physAddr[`ICACHE_ADDR_BITS-1:`ICACHE_BYTE_BITS+`ICACHE_OFFSET_BITS],
                    counter, {`ICACHE_BYTE_BITS{1'b0}}};

  // A single-word fill while disabled leaves the block marked invalid
  assign tagWData.valid = enable;
  assign tagWData.tag   = physTag;

  assign dataAddr = {set, newWordOffset};

  icacheController ctrl (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .paReady       (paReady),
    .way1Valid     (way1Entry.valid),
    .way2Valid     (way2Entry.valid),
    .curLru        (curLru),
    .busReady      (busReady),
    .wordOffset    (wordOffset),
    .way1Tag       (way1Entry.tag),
    .way2Tag       (way2Entry.tag),
    .physTag       (physTag),
    .counter       (counter),
    .newWordOffset (newWordOffset),
    .way1We        (way1We),
    .way2We        (way2We),
    .waySel        (waySel),
    .iStall        (iStall),
    .resetBlockOff (resetBlockOff),
    .busRequest    (busRequest)
  );

  cacheArray #(.entryT(cachePkg::tagEntryT), .depth(TagDepth)) way1Tags (
    .clk(clk), .reset(reset), .we(way1We), .wAddr(set), .rAddr(set),
    .wData(tagWData), .rData(way1Entry)
  );

  cacheArray #(.entryT(cachePkg::tagEntryT), .depth(TagDepth)) way2Tags (
    .clk(clk), .reset(reset), .we(way2We), .wAddr(set), .rAddr(set),
    .wData(tagWData), .rData(way2Entry)
  );

  cacheArray #(.entryT(busPkg::wordT), .depth(DataDepth)) way1Words (
    .clk(clk), .reset(reset), .we(way1We), .wAddr(dataAddr), .rAddr(dataAddr),
    .wData(busData), .rData(way1Data)
  );

  cacheArray #(.entryT(busPkg::wordT), .depth(DataDepth)) way2Words (
    .clk(clk), .reset(reset), .we(way2We), .wAddr(dataAddr), .rAddr(dataAddr),
    .wData(busData), .rData(way2Data)
  );

  lruTable lru (
    .clk      (clk),
    .reset    (reset),
    .access   (resetBlockOff),
    .set      (set),
    .usedWay1 (waySel),
    .curLru   (curLru)
  );

  assign instr = waySel ? way1Data : way2Data;

endmodule

/* verif/icache_chk.sv */
/*
  Handshake assertions for the instruction cache controller
*/
module icacheChk (
  input logic clk,
  input logic reset,
  input logic paReady,
  input logic busReady,
  input logic iStall,
  input logic busRequest,
  input logic way1We,
  input logic way2We
);

  timeunit 1ns;
  timeprecision 1ps;

  logic beatSeen;
  logic lastWay1;

  // Way written by the previous beat of the fill in progress
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatSeen <= 1'b0;
      lastWay1 <= 1'b0;
    end else if (!busRequest) begin
      beatSeen <= 1'b0;
    end else if (way1We || way2We) begin
      beatSeen <= 1'b1;
      lastWay1 <= way1We;
    end
  end

  // A fill holds the fetch stage and the bus until its next beat
  requestHoldsStall: assert property (
    @(posedge clk) disable iff (reset) (busRequest && !busReady) |=> (busRequest && iStall)
  ) else $error("busRequest or iStall dropped while a beat was still missing");

  // All beats of one block land in the same way
  fillKeepsWay: assert property (
    @(posedge clk) disable iff (reset)
      (beatSeen && (way1We || way2We)) |-> (way1We == lastWay1)
  ) else $error("a block fill switched ways between beats");

  // Idle out of reset until a fetch arrives
  quietAfterReset: assert property (
    @(posedge clk) ($past(reset) && !reset && !paReady) |-> (!iStall && !busRequest)
  ) else $error("stall or bus request raised right after reset");

endmodule

bind icacheController icacheChk handshakeChk (
  .clk        (clk),
  .reset      (reset),
  .paReady    (paReady),
  .busReady   (busReady),
  .iStall     (iStall),
  .busRequest (busRequest),
  .way1We     (way1We),
  .way2We     (way2We)
);

/* verif/instrCacheTb.sv */
/*
  Directed testbench for the instruction cache, with a bus memory
  model that answers misses after random gaps
*/
`include "icache_defs.svh"

module instrCacheTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClockPeriod   = 100;
  localparam int ResetCycles   = 16;
  localparam int NumAccesses   = 18;
  localparam int BlockWords    = 1 << `ICACHE_OFFSET_BITS;
  localparam int LongGap       = 15;
  localparam int TimeoutCycles =
    3 * ResetCycles + NumAccesses * (BlockWords * (LongGap + 2) + 4) + 100;

  // Memory contents are the address scrambled with a fixed pattern
  localparam busPkg::wordT MemPattern = 32'hA5C3_0F96;

  logic         clk, reset, enable, paReady, busReady;
  logic         iStall, busRequest;
  busPkg::addrT physAddr, busAddr;
  busPkg::wordT busData, instr;

  int           errorCount = 0;
  int           checkCount = 0;
  int           maxGap = 3;
  logic [31:0]  lcgState = 32'h5780_5de7;
  busPkg::addrT beatLog[$];

  instrCache dut (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .paReady    (paReady),
    .physAddr   (physAddr),
    .busReady   (busReady),
    .busData    (busData),
    .instr      (instr),
    .iStall     (iStall),
    .busRequest (busRequest),
    .busAddr    (busAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Idle cycles before the next beat
  function automatic int nextGap();
    logic [31:0] rnd;
    rnd = nextRandom();
    return int'(rnd[31:16]) % (maxGap + 1);
  endfunction

  function automatic busPkg::wordT memWord(input busPkg::addrT addr);
    return addr ^ MemPattern;
  endfunction

  function automatic busPkg::addrT makeAddr(input cachePkg::tagT tag,
                                            input cachePkg::setT set,
                                            input cachePkg::offsetT word);
    return {tag, set, word, {`ICACHE_BYTE_BITS{1'b0}}};
  endfunction

  // Bus memory: sample request and address mid-cycle, pulse busReady next cycle
  initial begin
    busPkg::addrT beatAddr;
    int idle;
    busReady = 1'b0;
    busData = '0;
    idle = 0;
    forever begin
      @(negedge clk);
      if (busRequest && idle > 0) begin
        idle--;
      end else if (busRequest) begin
        beatAddr = busAddr;
        @(posedge clk);
        #10;
        busReady = 1'b1;
        busData = memWord(beatAddr);
        beatLog.push_back(beatAddr);
        @(posedge clk);
        #10;
        busReady = 1'b0;
        idle = nextGap();
      end
    end
  end

  task automatic checkWord(input string name, input busPkg::wordT got,
                           input busPkg::wordT exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkTrue(input logic ok, input string what);
    checkCount++;
    assert (ok) else begin
      errorCount++;
      $display("Error: %s at %0t", what, $time);
    end
  endtask

  // One fetch; expBeats is 0 for a hit, 4 for a block fill, 1 when disabled
  task automatic access(input busPkg::addrT addr, input int expBeats);
    busPkg::addrT expAddr;
    logic stalled;
    beatLog.delete();
    @(posedge clk);
    #10;
    paReady = 1'b1;
    physAddr = addr;
    @(negedge clk);
    stalled = iStall;
    while (iStall) @(negedge clk);
    checkWord("instr", instr, memWord(addr));
    checkTrue(stalled == (expBeats != 0), "hit or miss differs from the expected one");
    checkTrue(beatLog.size() == expBeats,
              $sformatf("expected %0d bus beats, saw %0d", expBeats, beatLog.size()));
    if (beatLog.size() == expBeats) begin
      for (int i = 0; i < expBeats; i++) begin
        expAddr = (expBeats == 1) ? addr :
          {addr[`ICACHE_ADDR_BITS-1:`ICACHE_BYTE_BITS+`ICACHE_OFFSET_BITS],
           cachePkg::offsetT'(i), {`ICACHE_BYTE_BITS{1'b0}}};
        checkWord("busAddr", beatLog[i], expAddr);
      end
    end
    @(posedge clk);
    #10;
    paReady = 1'b0;
  endtask

  task automatic applyReset();
    @(posedge clk);
    #10;
    reset = 1'b1;
    paReady = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #10;
    reset = 1'b0;
  endtask

  task automatic idleAfterReset();
    @(negedge clk);
    checkTrue(!iStall && !busRequest, "stall or bus request while idle after reset");
  endtask

  task automatic coldMissThenHit();
    access(makeAddr(24'h001234, 4'h5, 2'd2), 4);
    for (int w = 0; w < BlockWords; w++) begin
      access(makeAddr(24'h001234, 4'h5, cachePkg::offsetT'(w)), 0);
    end
  endtask

  task automatic lruReplacement();
    busPkg::addrT addrA, addrB, addrC;
    addrA = makeAddr(24'h000A01, 4'h3, 2'd1);
    addrB = makeAddr(24'h000B02, 4'h3, 2'd2);
    addrC = makeAddr(24'h000C03, 4'h3, 2'd0);
    access(addrA, 4);
    access(addrB, 4);
    access(addrA, 0);
    access(addrB, 0);
    // A most recent, so C must take the way holding B
    access(addrA, 0);
    access(addrC, 4);
    access(addrA, 0);
    access(addrB, 4);
  endtask

  task automatic stalledBus();
    maxGap = LongGap;
    access(makeAddr(24'hABCDE0, 4'hC, 2'd3), 4);
    access(makeAddr(24'hABCDE0, 4'hC, 2'd1), 0);
    maxGap = 3;
  endtask

  task automatic disabledCache();
    @(posedge clk);
    #10;
    enable = 1'b0;
    access(makeAddr(24'h0F0F0F, 4'h9, 2'd1), 1);
    access(makeAddr(24'h0F0F0F, 4'h9, 2'd3), 1);
    @(posedge clk);
    #10;
    enable = 1'b1;
  endtask

  task automatic resetClearsValid();
    applyReset();
    idleAfterReset();
    access(makeAddr(24'h001234, 4'h5, 2'd2), 4);
  endtask

  initial begin
    #(TimeoutCycles * ClockPeriod);
    $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    reset = 1'b1;
    enable = 1'b1;
    paReady = 1'b0;
    physAddr = '0;
    repeat (ResetCycles) @(posedge clk);
    #10;
    reset = 1'b0;
    idleAfterReset();
    coldMissThenHit();
    lruReplacement();
    stalledBus();
    disabledCache();
    resetClearsValid();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
source/cache_pkg.sv
source/bus_pkg.sv
source/cacheArray.sv
source/lruTable.sv
source/icacheController.sv
source/instrCache.sv
verif/icache_chk.sv
verif/instrCacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module instrCacheTb -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/VinstrCacheTb" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
